// ==== source/fetch_defs.svh ====
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// first fetch address out of reset
`define FETCH_RESET_ADDR 32'h0000_1000

// fetch queue entries
`define FETCH_QUEUE_DEPTH 8

// pc bits used to index the counter table
`define BP_INDEX_BITS 6

`endif

// ==== source/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // rv32 opcodes that steer the next pc
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // one fetched word on its way to decode
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] inst;
        logic [7:0]  id;
    } fetch_pkt_t;

    // word aligned
    typedef struct packed {
        logic [31:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] inst;
    } mem_resp_t;

    // restart request from execute
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } redirect_t;

    // resolved conditional branch outcome
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        taken;
    } br_update_t;

endpackage

`default_nettype wire

// ==== source/branch_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module branch_predictor
    import fetch_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,

    input  wire logic [31:0] lookup_pc,
    output logic            pred_taken,

    input  wire br_update_t br_update
);

    localparam int IDX_W   = `BP_INDEX_BITS;
    localparam int ENTRIES = 1 << IDX_W;

    logic [1:0]       counters [ENTRIES];
    logic [IDX_W-1:0] lookup_idx;
    logic [IDX_W-1:0] update_idx;

    assign lookup_idx = lookup_pc[IDX_W+1:2];
    assign update_idx = br_update.pc[IDX_W+1:2];

    // msb of the counter is the prediction
    assign pred_taken = counters[lookup_idx][1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // weakly not-taken
            for (int i = 0; i < ENTRIES; i++) begin
                counters[i] <= 2'b01;
            end
        end else if (br_update.valid) begin
            if (br_update.taken) begin
                if (counters[update_idx] != 2'b11) begin
                    counters[update_idx] <= counters[update_idx] + 2'b01;
                end
            end else begin
                if (counters[update_idx] != 2'b00) begin
                    counters[update_idx] <= counters[update_idx] - 2'b01;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_unit
    import fetch_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,

    output logic             mem_req_valid,
    input  wire              mem_req_ready,
    output mem_req_t         mem_req,

    input  wire              mem_resp_valid,
    input  wire mem_resp_t   mem_resp,

    output logic             in_valid,
    input  wire              in_ready,
    output fetch_pkt_t       in_pkt,

    input  wire redirect_t   redirect,

    output logic [31:0]      lookup_pc,
    input  wire logic        pred_taken
);

    logic [31:0] pc;
    logic [31:0] req_addr;
    logic [7:0]  inst_id;
    logic        active;
    logic        outstanding;
    logic        squash;

    logic        req_fire;
    logic        resp_fire;

    logic [31:0] inst;
    logic [6:0]  opcode;
    logic [31:0] imm_j;
    logic [31:0] imm_b;
    logic [31:0] next_pc;

    // one request at a time, and only with room in the queue
    assign mem_req_valid = active && !outstanding && in_ready;
    assign mem_req.addr  = pc;

    assign req_fire  = mem_req_valid && mem_req_ready;
    assign resp_fire = mem_resp_valid && outstanding;

    // predictor looks at the word that is coming back
    assign lookup_pc = req_addr;

    assign inst   = mem_resp.inst;
    assign opcode = inst[6:0];

    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        next_pc = req_addr + 32'd4;
        if (opcode == OP_JAL) begin
            next_pc = req_addr + imm_j;
        end else if (opcode == OP_BRANCH && pred_taken) begin
            next_pc = req_addr + imm_b;
        end
    end

    // stale or same-cycle-redirected responses never reach the queue
    assign in_valid    = resp_fire && !squash && !redirect.valid;
    assign in_pkt.addr = req_addr;
    assign in_pkt.inst = inst;
    assign in_pkt.id   = inst_id;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active      <= 1'b0;
            outstanding <= 1'b0;
            squash      <= 1'b0;
            inst_id     <= 8'd0;
        end else begin
            active <= 1'b1;

            if (req_fire) begin
                outstanding <= 1'b1;
            end else if (resp_fire) begin
                outstanding <= 1'b0;
            end

            // request in flight across a redirect is dropped on return
            if (redirect.valid && ((outstanding && !mem_resp_valid) || req_fire)) begin
                squash <= 1'b1;
            end else if (resp_fire) begin
                squash <= 1'b0;
            end

            if (in_valid) begin
                inst_id <= inst_id + 8'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `FETCH_RESET_ADDR;
        end else if (redirect.valid) begin
            pc <= redirect.addr;
        end else if (in_valid) begin
            pc <= next_pc;
        end
    end

    // address of the request in flight
    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_addr <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_queue
    import fetch_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,

    input  wire              flush,

    input  wire              in_valid,
    output logic             in_ready,
    input  wire fetch_pkt_t  in_pkt,

    output logic             out_valid,
    input  wire              out_ready,
    output fetch_pkt_t       out_pkt
);

    localparam int DEPTH = `FETCH_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_pkt_t       entries [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic             wr_en;
    logic             rd_en;

    assign in_ready  = count < CNT_W'(DEPTH);
    assign out_valid = count != '0;
    assign out_pkt   = entries[rd_ptr];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage, flush wins over a write
    always_ff @(posedge clk) begin
        if (wr_en && !flush) begin
            entries[wr_ptr] <= in_pkt;
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_top
    import fetch_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,

    output logic             mem_req_valid,
    input  wire              mem_req_ready,
    output mem_req_t         mem_req,

    input  wire              mem_resp_valid,
    input  wire mem_resp_t   mem_resp,

    output logic             out_valid,
    input  wire              out_ready,
    output fetch_pkt_t       out_pkt,

    input  wire redirect_t   redirect,
    input  wire br_update_t  br_update
);

    logic        q_in_valid;
    logic        q_in_ready;
    fetch_pkt_t  q_in_pkt;
    logic [31:0] lookup_pc;
    logic        pred_taken;

    fetch_unit i_fetch_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req        (mem_req),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp       (mem_resp),
        .in_valid       (q_in_valid),
        .in_ready       (q_in_ready),
        .in_pkt         (q_in_pkt),
        .redirect       (redirect),
        .lookup_pc      (lookup_pc),
        .pred_taken     (pred_taken)
    );

    branch_predictor i_branch_predictor (
        .clk        (clk),
        .rst_n      (rst_n),
        .lookup_pc  (lookup_pc),
        .pred_taken (pred_taken),
        .br_update  (br_update)
    );

    // redirect also empties whatever decode has not taken yet
    fetch_queue i_fetch_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (redirect.valid),
        .in_valid  (q_in_valid),
        .in_ready  (q_in_ready),
        .in_pkt    (q_in_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pkt   (out_pkt)
    );

endmodule

`default_nettype wire

// ==== dv/fetch_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_chk
    import fetch_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire              mem_req_valid,
    input  wire              mem_req_ready,
    input  wire mem_req_t    mem_req,
    input  wire              mem_resp_valid,
    input  wire              out_valid,
    input  wire              out_ready,
    input  wire fetch_pkt_t  out_pkt,
    input  wire redirect_t   redirect
);

    logic busy;

    // request accepted, response not back yet
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (mem_req_valid && mem_req_ready) begin
            busy <= 1'b1;
        end else if (mem_resp_valid) begin
            busy <= 1'b0;
        end
    end

    // a redirect may move the pc of a waiting request
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready && !redirect.valid |=> mem_req_valid && $stable(mem_req))
        else $error("request dropped or changed while waiting for ready");

    out_held: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready && !redirect.valid |=> out_valid && $stable(out_pkt))
        else $error("output packet dropped or changed while stalled");

    one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> !mem_req_valid)
        else $error("new request while one is outstanding");

    reset_quiet: assert property (@(posedge clk)
        !rst_n && $past(!rst_n) |-> !mem_req_valid && !out_valid)
        else $error("valid output during reset");

endmodule

`default_nettype wire

// ==== dv/fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_tb
    import fetch_pkg::*;
();

    logic        clk;
    logic        rst_n;
    logic        mem_req_valid;
    logic        mem_req_ready;
    mem_req_t    mem_req;
    logic        mem_resp_valid;
    mem_resp_t   mem_resp;
    logic        out_valid;
    logic        out_ready;
    fetch_pkt_t  out_pkt;
    redirect_t   redirect;
    br_update_t  br_update;

    // reference model state
    fetch_pkt_t  exp_q[$];
    logic [1:0]  ctr [1 << `BP_INDEX_BITS];
    logic [31:0] exp_req_addr;
    logic [31:0] pend_addr;
    logic [7:0]  next_id;
    logic        pend;
    logic        stale;
    int unsigned wait_cnt;
    int unsigned stall_cnt;
    int unsigned pkt_count;
    int unsigned mismatch_errs;
    int unsigned other_errs;

    fetch_top i_fetch_top (.*);

    bind fetch_top fetch_chk i_fetch_chk (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // instruction image, a fixed function of the whole address
    function automatic logic [31:0] mem_word(input logic [31:0] addr, output logic [31:0] off);
        logic [31:0] h;
        h = (addr ^ (addr >> 13)) * 32'h9e37_79b1;
        h = h ^ (h >> 16);
        // 4 to 64 bytes either way, never zero
        off = (32'(h[7:4]) + 32'd1) << 2;
        if (h[8]) begin
            off = -off;
        end
        case (h[31:30])
            2'd2: return {off[20], off[10:1], off[11], off[19:12], h[13:9], OP_JAL};
            2'd3: return {off[12], off[10:5], h[24:12], off[4:1], off[11], OP_BRANCH};
            default: return {h[24:0], 7'b0010011};
        endcase
    endfunction

    function automatic logic [31:0] model_next_pc(input logic [31:0] addr);
        logic [31:0] inst;
        logic [31:0] off;
        inst = mem_word(addr, off);
        if (inst[6:0] == OP_JAL) begin
            return addr + off;
        end
        if (inst[6:0] == OP_BRANCH && ctr[addr[`BP_INDEX_BITS+1:2]][1]) begin
            return addr + off;
        end
        return addr + 32'd4;
    endfunction

    task automatic check_pkt(input fetch_pkt_t got, input fetch_pkt_t exp);
        if (got !== exp) begin
            mismatch_errs++;
            $write("Mismatch at %0d ns: out_pkt got addr=%h inst=%h id=%h", $time,
                   got.addr, got.inst, got.id);
            $display(" expected addr=%h inst=%h id=%h", exp.addr, exp.inst, exp.id);
        end
    endtask

    task automatic check_req(input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            mismatch_errs++;
            $display("Mismatch at %0d ns: mem_req.addr got %h expected %h", $time,
                     got.addr, exp.addr);
        end
    endtask

    task automatic reset_model();
        exp_q.delete();
        foreach (ctr[i]) begin
            ctr[i] = 2'b01;
        end
        exp_req_addr = `FETCH_RESET_ADDR;
        pend_addr    = '0;
        next_id      = '0;
        pend         = 1'b0;
        stale        = 1'b0;
        wait_cnt     = 0;
    endtask

    // memory responses and decode ready for the current cycle
    task automatic drive_memory();
        logic [31:0] off;
        mem_req_ready  = ($urandom_range(0, 3) != 0);
        mem_resp_valid = pend && wait_cnt == 0;
        mem_resp.inst  = '0;
        if (pend) begin
            mem_resp.inst = mem_word(pend_addr, off);
        end
        if (pend && wait_cnt != 0) begin
            wait_cnt--;
        end
        if (stall_cnt == 0 && $urandom_range(0, 49) == 0) begin
            stall_cnt = $urandom_range(10, 40);
        end
        if (stall_cnt != 0) begin
            out_ready = 1'b0;
            stall_cnt--;
        end else begin
            out_ready = ($urandom_range(0, 3) != 0);
        end
    endtask

    // everything the coming edge will see, in the order the rules apply it
    task automatic update_model();
        fetch_pkt_t new_pkt;
        mem_req_t   exp_req;
        logic [1:0] c;
        if (out_valid && out_ready) begin
            pkt_count++;
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("error at %0d ns: decode got a packet that was never fetched", $time);
            end else begin
                check_pkt(out_pkt, exp_q.pop_front());
            end
        end
        if (mem_resp_valid) begin
            // squashed or in the redirect cycle itself, never queued
            if (!stale && !redirect.valid) begin
                new_pkt.addr = pend_addr;
                new_pkt.inst = mem_resp.inst;
                new_pkt.id   = next_id;
                exp_q.push_back(new_pkt);
                next_id      = next_id + 8'd1;
                exp_req_addr = model_next_pc(pend_addr);
            end
            pend  = 1'b0;
            stale = 1'b0;
        end
        if (mem_req_valid && mem_req_ready) begin
            if (pend) begin
                other_errs++;
                $display("error at %0d ns: second request while one is outstanding", $time);
            end
            exp_req.addr = exp_req_addr;
            check_req(mem_req, exp_req);
            pend      = 1'b1;
            pend_addr = exp_req_addr;
            wait_cnt  = $urandom_range(0, 2);
            stale     = redirect.valid;
        end else if (redirect.valid && pend) begin
            stale = 1'b1;
        end
        if (br_update.valid) begin
            c = ctr[br_update.pc[`BP_INDEX_BITS+1:2]];
            if (br_update.taken && c != 2'b11) begin
                c = c + 2'b01;
            end else if (!br_update.taken && c != 2'b00) begin
                c = c - 2'b01;
            end
            ctr[br_update.pc[`BP_INDEX_BITS+1:2]] = c;
        end
        if (redirect.valid) begin
            exp_q.delete();
            exp_req_addr = redirect.addr;
        end
    endtask

    initial begin
        mem_req_ready  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp       = '0;
        out_ready      = 1'b0;
        stall_cnt      = 0;
        reset_model();
        forever begin
            @(posedge clk);
            #1;
            drive_memory();
            @(negedge clk);
            if (!rst_n) begin
                reset_model();
            end else begin
                update_model();
            end
        end
    end

    task automatic wait_packets(input int unsigned n);
        int unsigned start;
        int unsigned cyc;
        start = pkt_count;
        cyc   = 0;
        while (pkt_count < start + n && cyc < 2000) begin
            @(posedge clk);
            cyc++;
        end
        if (pkt_count < start + n) begin
            other_errs++;
            $display("timeout at %0d ns: no new packet at decode in %0d cycles", $time, cyc);
        end
    endtask

    // groups of four saturate a counter from any state
    task automatic train_burst();
        logic [31:0] pc;
        logic        taken;
        for (int g = 0; g < 3; g++) begin
            pc    = {24'h0000_10, 6'($urandom_range(0, 63)), 2'b00};
            taken = 1'($urandom_range(0, 1));
            for (int k = 0; k < 4; k++) begin
                @(posedge clk);
                #1;
                br_update.valid = 1'b1;
                br_update.pc    = pc;
                br_update.taken = taken;
            end
        end
    endtask

    task automatic send_redirect(input logic [31:0] addr);
        @(posedge clk);
        #1;
        br_update      = '0;
        redirect.valid = 1'b1;
        redirect.addr  = addr;
        @(posedge clk);
        #1;
        redirect = '0;
    endtask

    initial begin
        void'($urandom(32'h37b));
        mismatch_errs = 0;
        other_errs    = 0;
        pkt_count     = 0;
        rst_n         = 1'b0;
        redirect      = '0;
        br_update     = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait_packets(8);
        for (int r = 0; r < 40; r++) begin
            repeat ($urandom_range(20, 120)) @(posedge clk);
            train_burst();
            send_redirect({20'h0_0001, 10'($urandom_range(0, 1023)), 2'b00});
            wait_packets(4);
        end
        if (pkt_count < 200) begin
            other_errs++;
            $display("error: only %0d packets reached decode", pkt_count);
        end
        $display("errors: %0d mismatches, %0d other, %0d packets checked",
                 mismatch_errs, other_errs, pkt_count);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(100 * 400000);
        $display("timeout at %0d ns: simulation did not finish", $time);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+source
source/fetch_pkg.sv
source/branch_predictor.sv
source/fetch_unit.sv
source/fetch_queue.sv
source/fetch_top.sv
dv/fetch_chk.sv
dv/fetch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module fetch_tb -f flist.f; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vfetch_tb)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TB PASSED" <<< "$sim_out"; then
    exit 0
fi
exit 1
